//--- source/controlCfg.svh
`ifndef CONTROL_CFG_SVH
`define CONTROL_CFG_SVH

// instruction word
`define INSTR_WIDTH 32

// primary opcode field
`define OPCODE_RTYPE 6'd0
`define OPCODE_JUMP  6'd2

// funct field of R-type words
`define FUNCT_MULT 6'd24
`define FUNCT_DIV  6'd26
`define FUNCT_MFHI 6'd16
`define FUNCT_MFLO 6'd18
`define FUNCT_JR   6'd8

// cycles with HI/LO write enabled, 1 to 7
`define MULT_DIV_CYCLES 2

`endif

//--- source/controlPkg.sv
`include "controlCfg.svh"

package controlPkg;

    // R-type field layout
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFields;

    // J-type field layout, target fills the rest of the word
    typedef struct packed {
        logic [5:0]              opcode;
        logic [`INSTR_WIDTH-7:0] target;
    } jFields;

    // one instruction word, two readings
    typedef union packed {
        rFields rType;
        jFields jType;
    } instrWord;

    typedef enum logic [2:0] {
        opMult,
        opDiv,
        opMfhi,
        opMflo,
        opJr,
        opJump,
        opIllegal
    } opClass;

    typedef enum logic [3:0] {
        stReset,
        stFetch,
        stDecode,
        stMultDivStart,
        stMultDivWrite,
        stMultDivCheck,
        stMoveHi,
        stMoveLo,
        stJumpReg,
        stJump,
        stExcSave,
        stExcJump
    } ctrlState;

    typedef enum logic [1:0] {
        causeNone     = 2'd0,
        causeOpcode   = 2'd1,
        causeOverflow = 2'd2,
        causeDivZero  = 2'd3
    } excCause;

    // PC mux select
    typedef enum logic [1:0] {
        selAluResult  = 2'd0,
        selExcVector  = 2'd1,
        selJumpTarget = 2'd2,
        selRegister   = 2'd3
    } pcSel;

    // register file write data select
    typedef enum logic [2:0] {
        regFromAlu = 3'd0,
        regFromHi  = 3'd2,
        regFromLo  = 3'd3
    } regSrc;

endpackage

//--- source/instrDecoder.sv
`timescale 1ns/1ns
`include "controlCfg.svh"

module instrDecoder (
    input  controlPkg::instrWord instr,
    output controlPkg::opClass   opClass,
    output logic                 isMult
);

    // R-type words are told apart by funct only
    always_comb begin
        opClass = controlPkg::opIllegal;
        if (instr.rType.opcode == `OPCODE_RTYPE) begin
            case (instr.rType.funct)
                `FUNCT_MULT: begin
                    opClass = controlPkg::opMult;
                end
                `FUNCT_DIV: begin
                    opClass = controlPkg::opDiv;
                end
                `FUNCT_MFHI: begin
                    opClass = controlPkg::opMfhi;
                end
                `FUNCT_MFLO: begin
                    opClass = controlPkg::opMflo;
                end
                `FUNCT_JR: begin
                    opClass = controlPkg::opJr;
                end
                default: begin
                    opClass = controlPkg::opIllegal;
                end
            endcase
        end else if (instr.jType.opcode == `OPCODE_JUMP) begin
            // target itself goes straight to the datapath
            opClass = controlPkg::opJump;
        end
    end

    // picks overflow vs divZero in the check state
    assign isMult = (opClass == controlPkg::opMult);

endmodule

//--- source/controlSequencer.sv
`timescale 1ns/1ns
`include "controlCfg.svh"

module controlSequencer (
    input  logic                 clk,
    input  logic                 reset,
    input  controlPkg::opClass   opClass,
    input  logic                 isMult,
    input  logic                 divZero,
    input  logic                 overflow,
    output controlPkg::ctrlState state,
    output controlPkg::excCause  cause
);

    // last value of the write counter
    localparam logic [2:0] lastCount = 3'(`MULT_DIV_CYCLES - 1);

    controlPkg::ctrlState nextState;
    controlPkg::excCause  nextCause;
    logic [2:0]           count;
    logic [2:0]           nextCount;
    logic                 flagSet;

    // flag belonging to the running operation
    assign flagSet = isMult ? overflow : divZero;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= controlPkg::stReset;
            cause <= controlPkg::causeNone;
            count <= 3'd0;
        end else begin
            state <= nextState;
            cause <= nextCause;
            count <= nextCount;
        end
    end

    always_comb begin
        nextState = state;
        nextCause = cause;
        nextCount = count;
        case (state)
            controlPkg::stReset: begin
                nextState = controlPkg::stFetch;
            end
            controlPkg::stFetch: begin
                nextState = controlPkg::stDecode;
            end
            controlPkg::stDecode: begin
                case (opClass)
                    controlPkg::opMult,
                    controlPkg::opDiv: begin
                        nextState = controlPkg::stMultDivStart;
                    end
                    controlPkg::opMfhi: begin
                        nextState = controlPkg::stMoveHi;
                    end
                    controlPkg::opMflo: begin
                        nextState = controlPkg::stMoveLo;
                    end
                    controlPkg::opJr: begin
                        nextState = controlPkg::stJumpReg;
                    end
                    controlPkg::opJump: begin
                        nextState = controlPkg::stJump;
                    end
                    default: begin
                        nextState = controlPkg::stExcSave;
                        nextCause = controlPkg::causeOpcode;
                    end
                endcase
            end
            controlPkg::stMultDivStart: begin
                nextState = controlPkg::stMultDivWrite;
                nextCount = 3'd0;
            end
            controlPkg::stMultDivWrite: begin
                // HI/LO written once per cycle here
                if (count == lastCount) begin
                    nextState = controlPkg::stMultDivCheck;
                end else begin
                    nextCount = count + 3'd1;
                end
            end
            controlPkg::stMultDivCheck: begin
                if (flagSet) begin
                    nextState = controlPkg::stExcSave;
                    nextCause = isMult ? controlPkg::causeOverflow
                                       : controlPkg::causeDivZero;
                end else begin
                    nextState = controlPkg::stFetch;
                end
            end
            controlPkg::stMoveHi,
            controlPkg::stMoveLo,
            controlPkg::stJumpReg,
            controlPkg::stJump: begin
                nextState = controlPkg::stFetch;
            end
            controlPkg::stExcSave: begin
                nextState = controlPkg::stExcJump;
            end
            controlPkg::stExcJump: begin
                // cause is dropped once the handler is entered
                nextState = controlPkg::stFetch;
                nextCause = controlPkg::causeNone;
            end
            default: begin
                nextState = controlPkg::stReset;
                nextCause = controlPkg::causeNone;
            end
        endcase
    end

endmodule

//--- source/controlEncoder.sv
`timescale 1ns/1ns

module controlEncoder (
    input  controlPkg::ctrlState state,
    input  controlPkg::excCause  cause,
    output logic                 pcWrite,
    output logic                 memRead,
    output logic                 irWrite,
    output logic                 iOrD,
    output logic                 multOrDiv,
    output logic                 hiWrite,
    output logic                 loWrite,
    output logic                 regWrite,
    output logic                 regDst,
    output logic                 epcWrite,
    output controlPkg::pcSel     pcSource,
    output controlPkg::regSrc    memToReg,
    output logic [1:0]           aluSrcA,
    output logic [2:0]           aluSrcB,
    output logic [2:0]           aluOp,
    output controlPkg::excCause  exceptionCause
);

    // ALU operation codes
    localparam logic [2:0] aluPass = 3'b000;
    localparam logic [2:0] aluAdd  = 3'b001;
    localparam logic [2:0] aluSub  = 3'b010;

    always_comb begin
        pcWrite        = 1'b0;
        memRead        = 1'b0;
        irWrite        = 1'b0;
        iOrD           = 1'b0;
        multOrDiv      = 1'b0;
        hiWrite        = 1'b0;
        loWrite        = 1'b0;
        regWrite       = 1'b0;
        regDst         = 1'b0;
        epcWrite       = 1'b0;
        pcSource       = controlPkg::selAluResult;
        memToReg       = controlPkg::regFromAlu;
        aluSrcA        = 2'b00;
        aluSrcB        = 3'b000;
        aluOp          = aluPass;
        exceptionCause = controlPkg::causeNone;
        case (state)
            controlPkg::stFetch: begin
                // read at PC, latch IR, PC <= PC + 4
                memRead = 1'b1;
                irWrite = 1'b1;
                pcWrite = 1'b1;
                aluSrcB = 3'b001;
                aluOp   = aluAdd;
            end
            controlPkg::stMultDivStart: begin
                multOrDiv = 1'b1;
            end
            controlPkg::stMultDivWrite: begin
                multOrDiv = 1'b1;
                hiWrite   = 1'b1;
                loWrite   = 1'b1;
            end
            controlPkg::stMoveHi: begin
                regWrite = 1'b1;
                regDst   = 1'b1;
                memToReg = controlPkg::regFromHi;
            end
            controlPkg::stMoveLo: begin
                regWrite = 1'b1;
                regDst   = 1'b1;
                memToReg = controlPkg::regFromLo;
            end
            controlPkg::stJumpReg: begin
                // rs passes through the ALU into PC
                pcWrite  = 1'b1;
                aluSrcA  = 2'b01;
                pcSource = controlPkg::selRegister;
            end
            controlPkg::stJump: begin
                pcWrite  = 1'b1;
                pcSource = controlPkg::selJumpTarget;
            end
            controlPkg::stExcSave: begin
                // EPC gets PC - 4, the faulting instruction
                epcWrite       = 1'b1;
                aluOp          = aluSub;
                aluSrcB        = 3'b001;
                exceptionCause = cause;
            end
            controlPkg::stExcJump: begin
                pcWrite        = 1'b1;
                pcSource       = controlPkg::selExcVector;
                exceptionCause = cause;
            end
            default: begin
                // reset, decode and check cycles drive nothing
            end
        endcase
    end

endmodule

//--- source/controlUnit.sv
`timescale 1ns/1ns

module controlUnit (
    input  logic                 clk,
    input  logic                 reset,
    input  controlPkg::instrWord instr,
    input  logic                 divZero,
    input  logic                 overflow,
    output logic                 pcWrite,
    output logic                 memRead,
    output logic                 irWrite,
    output logic                 iOrD,
    output logic                 multOrDiv,
    output logic                 hiWrite,
    output logic                 loWrite,
    output logic                 regWrite,
    output logic                 regDst,
    output logic                 epcWrite,
    output controlPkg::pcSel     pcSource,
    output controlPkg::regSrc    memToReg,
    output logic [1:0]           aluSrcA,
    output logic [2:0]           aluSrcB,
    output logic [2:0]           aluOp,
    output controlPkg::excCause  exceptionCause
);

    controlPkg::opClass   decodedClass;
    logic                 isMult;
    controlPkg::ctrlState state;
    controlPkg::excCause  cause;

    instrDecoder decoder0 (
        .instr   (instr),
        .opClass (decodedClass),
        .isMult  (isMult)
    );

    controlSequencer sequencer0 (
        .clk      (clk),
        .reset    (reset),
        .opClass  (decodedClass),
        .isMult   (isMult),
        .divZero  (divZero),
        .overflow (overflow),
        .state    (state),
        .cause    (cause)
    );

    // strobes depend on the current state alone
    controlEncoder encoder0 (
        .state          (state),
        .cause          (cause),
        .pcWrite        (pcWrite),
        .memRead        (memRead),
        .irWrite        (irWrite),
        .iOrD           (iOrD),
        .multOrDiv      (multOrDiv),
        .hiWrite        (hiWrite),
        .loWrite        (loWrite),
        .regWrite       (regWrite),
        .regDst         (regDst),
        .epcWrite       (epcWrite),
        .pcSource       (pcSource),
        .memToReg       (memToReg),
        .aluSrcA        (aluSrcA),
        .aluSrcB        (aluSrcB),
        .aluOp          (aluOp),
        .exceptionCause (exceptionCause)
    );

endmodule

//--- verification/controlUnit_checker.sv
`timescale 1ns/1ns

module controlUnitChecker (
    input logic                clk,
    input logic                reset,
    input logic                pcWrite,
    input logic                memRead,
    input logic                irWrite,
    input logic                iOrD,
    input logic                multOrDiv,
    input logic                hiWrite,
    input logic                loWrite,
    input logic                regWrite,
    input logic                regDst,
    input logic                epcWrite,
    input controlPkg::pcSel    pcSource,
    input controlPkg::excCause exceptionCause
);

    // HI and LO always move together
    assert property (@(posedge clk) disable iff (reset) hiWrite == loWrite)
        else $error("hiWrite and loWrite differ");

    assert property (@(posedge clk) disable iff (reset) irWrite |-> memRead)
        else $error("irWrite without memRead");

    // EPC save is followed by the jump to the handler
    assert property (@(posedge clk) disable iff (reset)
        epcWrite |=> pcWrite && pcSource == controlPkg::selExcVector)
        else $error("epcWrite not followed by pcWrite to the exception vector");

    assert property (@(posedge clk) reset |-> !(pcWrite || memRead || irWrite || iOrD ||
        multOrDiv || hiWrite || loWrite || regWrite || regDst || epcWrite) &&
        pcSource == controlPkg::selAluResult && exceptionCause == controlPkg::causeNone)
        else $error("strobe active during reset");

endmodule

bind controlUnit controlUnitChecker checker0 (.*);

//--- verification/controlUnitTb.sv
`timescale 1ns/1ns
`include "controlCfg.svh"

module controlUnitTb;

    localparam int numTests = 14;
    localparam int cycleLimit = numTests * (6 + `MULT_DIV_CYCLES + 2) + 50;

    // kinds of execute strobe
    localparam int exNone = 0;
    localparam int exRegWrite = 1;
    localparam int exPcWrite = 2;
    localparam int exHiLo = 3;

    logic                 clk;
    logic                 reset;
    controlPkg::instrWord instr;
    logic                 divZero;
    logic                 overflow;
    logic                 pcWrite;
    logic                 memRead;
    logic                 irWrite;
    logic                 iOrD;
    logic                 multOrDiv;
    logic                 hiWrite;
    logic                 loWrite;
    logic                 regWrite;
    logic                 regDst;
    logic                 epcWrite;
    controlPkg::pcSel     pcSource;
    controlPkg::regSrc    memToReg;
    logic [1:0]           aluSrcA;
    logic [2:0]           aluSrcB;
    logic [2:0]           aluOp;
    controlPkg::excCause  exceptionCause;

    integer seed = 8;
    int     errorCount = 0;
    int     failedTests = 0;
    int     doneCount = 0;
    int     cycleCount = 0;

    // expectations queued by the driver and consumed by the monitor
    string nameQ[$];
    int    cyclesQ[$];
    int    causeQ[$];
    int    strobeQ[$];
    int    selQ[$];

    // state of the test being watched
    logic  active = 1'b0;
    int    testIndex = 0;
    string curName;
    int    expCycles;
    int    expCause;
    int    expStrobe;
    int    expSel;
    int    errBase;
    int    cycleIdx;
    int    hiCount;
    int    loCount;
    int    regCount;
    int    pcCount;
    int    epcCount;
    int    regCycle;
    int    regSel;
    int    pcCycle;
    int    pcSelSeen;
    int    epcCycle;
    int    seenCause;

    controlUnit dut0 (.*);

    initial clk = 1'b0;
    always #2 clk = ~clk;

    function automatic void predictResult(
        input  controlPkg::instrWord word,
        input  logic                 ovf,
        input  logic                 dz,
        output int                   cycles,
        output controlPkg::excCause  cause,
        output int                   strobe,
        output int                   sel
    );
        // four cycles through the trap states for anything unknown
        cycles = 4;
        cause  = controlPkg::causeOpcode;
        strobe = exNone;
        sel    = 0;
        if (word.rType.opcode == `OPCODE_RTYPE) begin
            case (word.rType.funct)
                `FUNCT_MULT, `FUNCT_DIV: begin
                    cycles = 4 + `MULT_DIV_CYCLES;
                    cause  = controlPkg::causeNone;
                    strobe = exHiLo;
                    if (word.rType.funct == `FUNCT_MULT && ovf) begin
                        cause  = controlPkg::causeOverflow;
                        cycles = cycles + 2;
                    end else if (word.rType.funct == `FUNCT_DIV && dz) begin
                        cause  = controlPkg::causeDivZero;
                        cycles = cycles + 2;
                    end
                end
                `FUNCT_MFHI, `FUNCT_MFLO: begin
                    cycles = 3;
                    cause  = controlPkg::causeNone;
                    strobe = exRegWrite;
                    sel    = (word.rType.funct == `FUNCT_MFHI) ? int'(controlPkg::regFromHi)
                                                              : int'(controlPkg::regFromLo);
                end
                `FUNCT_JR: begin
                    cycles = 3;
                    cause  = controlPkg::causeNone;
                    strobe = exPcWrite;
                    sel    = int'(controlPkg::selRegister);
                end
                default: begin
                    // unknown funct keeps the trap values
                end
            endcase
        end else if (word.jType.opcode == `OPCODE_JUMP) begin
            cycles = 3;
            cause  = controlPkg::causeNone;
            strobe = exPcWrite;
            sel    = int'(controlPkg::selJumpTarget);
        end
    endfunction

    function automatic logic randomBit();
        return 1'($random(seed));
    endfunction

    function automatic controlPkg::instrWord rWord(input logic [5:0] funct);
        controlPkg::instrWord word;
        word = 32'($random(seed));
        word.rType.opcode = `OPCODE_RTYPE;
        word.rType.shamt = 5'd0;
        word.rType.funct = funct;
        return word;
    endfunction

    function automatic controlPkg::instrWord jumpWord();
        controlPkg::instrWord word;
        word = 32'($random(seed));
        word.jType.opcode = `OPCODE_JUMP;
        return word;
    endfunction

    function automatic controlPkg::instrWord illegalWord(input logic sameOpcode);
        controlPkg::instrWord word;
        word = 32'($random(seed));
        if (sameOpcode) begin
            word.rType.opcode = `OPCODE_RTYPE;
            while (word.rType.funct inside {`FUNCT_MULT, `FUNCT_DIV, `FUNCT_MFHI,
                                            `FUNCT_MFLO, `FUNCT_JR}) begin
                word.rType.funct = 6'($random(seed));
            end
        end else begin
            while (word.rType.opcode == `OPCODE_RTYPE || word.rType.opcode == `OPCODE_JUMP) begin
                word.rType.opcode = 6'($random(seed));
            end
        end
        return word;
    endfunction

    function automatic int strobeBits();
        return int'({pcWrite, memRead, irWrite, iOrD, multOrDiv, hiWrite, loWrite, regWrite,
                     regDst, epcWrite, pcSource, memToReg, aluSrcA, aluSrcB, aluOp,
                     exceptionCause});
    endfunction

    task automatic checkValue(input string name, input string field, input int expected,
                              input int actual);
        assert (expected == actual) else begin
            $display("ERROR %s %s: expected %0d, actual %0d", name, field, expected, actual);
            errorCount++;
        end
    endtask

    task automatic queueTest(input string name, input controlPkg::instrWord word,
                             input logic ovf, input logic dz);
        int                  cycles;
        controlPkg::excCause cause;
        int                  strobe;
        int                  sel;
        instr = word;
        overflow = ovf;
        divZero = dz;
        predictResult(word, ovf, dz, cycles, cause, strobe, sel);
        nameQ.push_back(name);
        cyclesQ.push_back(cycles);
        causeQ.push_back(int'(cause));
        strobeQ.push_back(strobe);
        selQ.push_back(sel);
    endtask

    // returns 1 ns after the edge that enters the next fetch
    task automatic waitFetch();
        do begin
            @(posedge clk);
            #1;
        end while (!irWrite);
    endtask

    task automatic openTest();
        if (nameQ.size() == 0) begin
            active = 1'b0;
        end else begin
            active = 1'b1;
            testIndex++;
            curName = nameQ.pop_front();
            expCycles = cyclesQ.pop_front();
            expCause = causeQ.pop_front();
            expStrobe = strobeQ.pop_front();
            expSel = selQ.pop_front();
            errBase = errorCount;
            cycleIdx = 0;
            hiCount = 0;
            loCount = 0;
            regCount = 0;
            pcCount = 0;
            epcCount = 0;
            regCycle = -1;
            regSel = -1;
            pcCycle = -1;
            pcSelSeen = -1;
            epcCycle = -1;
            seenCause = int'(controlPkg::causeNone);
        end
    endtask

    task automatic recordStrobes();
        if (hiWrite) begin
            hiCount++;
        end
        if (loWrite) begin
            loCount++;
        end
        if (regWrite) begin
            regCount++;
            regCycle = cycleIdx;
            regSel = int'(memToReg);
        end
        if (pcWrite) begin
            pcCount++;
            pcCycle = cycleIdx;
            pcSelSeen = int'(pcSource);
        end
        if (epcWrite) begin
            epcCount++;
            epcCycle = cycleIdx;
        end
        if (exceptionCause != controlPkg::causeNone) begin
            seenCause = int'(exceptionCause);
        end
    endtask

    task automatic closeTest();
        logic trap;
        trap = (expCause != int'(controlPkg::causeNone));
        checkValue(curName, "cycles", expCycles, cycleIdx);
        checkValue(curName, "exceptionCause", expCause, seenCause);
        checkValue(curName, "hiWrite pulses", (expStrobe == exHiLo) ? `MULT_DIV_CYCLES : 0,
                   hiCount);
        checkValue(curName, "loWrite pulses", (expStrobe == exHiLo) ? `MULT_DIV_CYCLES : 0,
                   loCount);
        checkValue(curName, "regWrite pulses", (expStrobe == exRegWrite) ? 1 : 0, regCount);
        checkValue(curName, "epcWrite pulses", trap ? 1 : 0, epcCount);
        checkValue(curName, "pcWrite pulses", (expStrobe == exPcWrite || trap) ? 1 : 0,
                   pcCount);
        if (expStrobe == exRegWrite) begin
            checkValue(curName, "regWrite cycle", 2, regCycle);
            checkValue(curName, "memToReg", expSel, regSel);
        end
        if (expStrobe == exPcWrite) begin
            checkValue(curName, "pcWrite cycle", 2, pcCycle);
            checkValue(curName, "pcSource", expSel, pcSelSeen);
        end
        if (trap) begin
            // save and jump are the last two cycles before the next fetch
            checkValue(curName, "epcWrite cycle", expCycles - 2, epcCycle);
            checkValue(curName, "pcWrite cycle", expCycles - 1, pcCycle);
            checkValue(curName, "pcSource", int'(controlPkg::selExcVector), pcSelSeen);
        end
        if (errorCount != errBase) begin
            failedTests++;
        end
        $display("test %0d %s: %s", testIndex, curName, (errorCount == errBase) ? "ok" : "failed");
        doneCount++;
    endtask

    // monitor sampling once per cycle between the edges
    always @(negedge clk) begin
        if (active) begin
            cycleIdx++;
        end
        if (!reset && irWrite) begin
            if (active) begin
                closeTest();
            end
            openTest();
        end else if (active) begin
            recordStrobes();
        end
    end

    initial begin
        int waitCycles;
        reset = 1'b1;
        instr = '0;
        divZero = 1'b0;
        overflow = 1'b0;
        repeat (7) @(posedge clk);
        @(negedge clk);
        checkValue("reset", "strobes during reset", 0, strobeBits());
        @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        checkValue("reset", "strobes after reset", 0, strobeBits());
        waitCycles = 0;
        while (!irWrite) begin
            @(posedge clk);
            #1;
            waitCycles++;
        end
        assert (waitCycles <= 2) else begin
            $display("ERROR reset first irWrite: expected at most 2 cycles, actual %0d",
                     waitCycles);
            errorCount++;
        end
        if (errorCount != 0) begin
            failedTests++;
        end
        $display("test 0 reset: %s", (errorCount == 0) ? "ok" : "failed");
        for (int i = 0; i < numTests; i++) begin
            if (i > 0) begin
                waitFetch();
            end
            case (i)
                0: queueTest("mfhi", rWord(`FUNCT_MFHI), randomBit(), randomBit());
                1: queueTest("mflo", rWord(`FUNCT_MFLO), randomBit(), randomBit());
                2: queueTest("multNoOverflow", rWord(`FUNCT_MULT), 1'b0, randomBit());
                3: queueTest("divNonZero", rWord(`FUNCT_DIV), randomBit(), 1'b0);
                4: queueTest("multOverflow", rWord(`FUNCT_MULT), 1'b1, randomBit());
                5: queueTest("divByZero", rWord(`FUNCT_DIV), randomBit(), 1'b1);
                6: queueTest("jr", rWord(`FUNCT_JR), randomBit(), randomBit());
                7: queueTest("j", jumpWord(), randomBit(), randomBit());
                default: queueTest(i[0] ? "illegalOpcode" : "illegalFunct", illegalWord(!i[0]),
                                   randomBit(), randomBit());
            endcase
        end
        // the next fetch closes the last test
        waitFetch();
        wait (doneCount == numTests);
        $display("summary: %0d tests, %0d failed, %0d errors", numTests + 1, failedTests,
                 errorCount);
        if (errorCount == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout: the run did not finish within %0d cycles", cycleLimit);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

//--- sources.f
+incdir+source
source/controlPkg.sv
source/instrDecoder.sv
source/controlSequencer.sv
source/controlEncoder.sv
source/controlUnit.sv
verification/controlUnit_checker.sv
verification/controlUnitTb.sv

//--- run.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
    -f sources.f --top-module controlUnitTb -o controlUnitSim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/controlUnitSim > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -qx "PASS: all tests" "$logFile"; then
    exit 0
fi
exit 1
